// ==== verif/video_patterns.txt ====
# w word data_hex | r word expected_hex
# f mode active_px hsync_px vsync_lines line_len draw_lines colour_hex
w 1 12345678
w 2 abcdef55
w 3 0000000a
w 5 00000007
w 0 00000ffc
r 0 00000ffc
r 1 12345640
r 2 abcdef40
r 3 0000000a
r 4 00000000
r 5 00000007
w 3 00000002
w 4 00204080
w 3 00000005
w 4 00c01030
w 3 00000009
w 4 0055aa33
w 5 00000002
w 0 00000001
r 0 00000001
f 1 640 96 2 800 480 204080
w 5 00000005
w 0 00000003
f 3 1280 40 5 1650 720 c01030

// ==== project.f ====
source/video_pkg.sv
source/video_regs.sv
source/video_timing.sv
source/pixel_color.sv
source/tmds_encoder.sv
source/video_controller.sv
verif/video_controller_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f project.f --top-module video_controller_tb -o video_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/video_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  exit 0
fi
exit 1

// ==== verif/video_controller_tb.sv ====
`timescale 1ns/1ns

module video_controller_tb;

  localparam logic [9:0] code_idle = 10'b1101010100;  // {vsync, hsync} = 00
  localparam logic [9:0] code_h    = 10'b0010101011;
  localparam logic [9:0] code_v    = 10'b0101010100;
  localparam logic [9:0] code_hv   = 10'b1010101011;
  localparam int frame_cycles_max  = 1650 * 750;     // 1280x720 frame

  logic clk = 1'b0;
  logic reset;
  video_pkg::apb_req_t    apb;
  logic [31:0]            prdata;
  logic                   pready;
  video_pkg::video_mode_e video_mode;
  logic [9:0]             tmds_red;
  logic [9:0]             tmds_green;
  logic [9:0]             tmds_blue;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int limit_cycles = 0;

  video_controller UUT (
    .clk(clk), .reset(reset), .apb(apb), .prdata(prdata), .pready(pready),
    .video_mode(video_mode), .tmds_red(tmds_red), .tmds_green(tmds_green),
    .tmds_blue(tmds_blue)
  );

  always #2 clk = ~clk;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic apb_write(input int word, input logic [31:0] data);
    @(negedge clk);
    apb.paddr   = 5'(word << 2);
    apb.psel    = 1'b1;
    apb.pwrite  = 1'b1;
    apb.pwdata  = data;
    @(negedge clk);
    apb.penable = 1'b1;  // Access phase
    @(negedge clk);
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b0;
  endtask

  task automatic apb_read(input int word, output logic [31:0] data, output logic ready);
    @(negedge clk);
    apb.paddr   = 5'(word << 2);
    apb.psel    = 1'b1;
    @(negedge clk);
    apb.penable = 1'b1;
    data        = prdata;
    ready       = pready;
    @(negedge clk);
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
  endtask

  function automatic bit is_control(input logic [9:0] sym);
    return sym == code_idle || sym == code_h || sym == code_v || sym == code_hv;
  endfunction

  // Undo the bit 9 inversion, then the XOR or XNOR chain
  function automatic logic [7:0] decode_symbol(input logic [9:0] sym);
    logic [7:0] q;
    logic [7:0] d;
    q    = sym[9] ? ~sym[7:0] : sym[7:0];
    d[0] = q[0];
    for (int i = 1; i < 8; i++) begin
      d[i] = sym[8] ? q[i] ^ q[i-1] : ~(q[i] ^ q[i-1]);
    end
    return d;
  endfunction

  // Measures from the second vsync rise to the third, lines split at hsync rise
  task automatic measure_frame(input string name, input int exp_active, input int exp_hsync,
                               input int exp_vsync, input int exp_len, input int exp_lines,
                               input logic [23:0] exp_color);
    logic        hs;
    logic        vs;
    logic        hs_prev;
    logic        vs_prev;
    logic        in_line;
    logic [9:0]  sym [3];
    logic [7:0]  dec;
    logic [23:0] color_seen;
    int rises;
    int line_len;
    int hs_cnt;
    int act_cnt;
    int len_seen;
    int hs_seen;
    int act_seen;
    int draw_lines;
    int vs_lines;
    int dc_bad;
    int dc_sum [3];
    hs_prev = 1'b1;
    vs_prev = 1'b1;
    in_line = 1'b0;
    rises = 0;
    line_len = 0;
    hs_cnt = 0;
    act_cnt = 0;
    len_seen = exp_len;
    hs_seen = exp_hsync;
    act_seen = exp_active;
    draw_lines = 0;
    vs_lines = 0;
    dc_bad = 0;
    dc_sum = '{0, 0, 0};
    color_seen = exp_color;
    while (rises < 3) begin
      @(negedge clk);
      sym[0] = tmds_red;
      sym[1] = tmds_green;
      sym[2] = tmds_blue;
      hs = tmds_blue == code_h || tmds_blue == code_hv;
      vs = tmds_blue == code_v || tmds_blue == code_hv;
      if (vs && !vs_prev) rises++;
      if (rises == 2) begin
        if (hs && !hs_prev) begin
          if (in_line) begin
            if (line_len != exp_len) len_seen = line_len;
            if (hs_cnt != exp_hsync) hs_seen = hs_cnt;
            if (act_cnt != 0) begin
              draw_lines++;
              if (act_cnt != exp_active) act_seen = act_cnt;
            end
          end
          in_line = 1'b1;
          line_len = 0;
          hs_cnt = 0;
          act_cnt = 0;
          dc_sum = '{0, 0, 0};
          if (vs) vs_lines++;
        end
        line_len++;
        if (hs) hs_cnt++;
        if (!is_control(tmds_blue)) begin
          act_cnt++;
          for (int c = 0; c < 3; c++) begin
            dec = decode_symbol(sym[c]);
            if (dec != exp_color[23-8*c -: 8]) color_seen[23-8*c -: 8] = dec;
            dc_sum[c] = dc_sum[c] + 2 * $countones(sym[c]) - 10;
            if (dc_sum[c] > 10 || dc_sum[c] < -10) dc_bad++;
          end
        end
      end
      hs_prev = hs;
      vs_prev = vs;
    end
    compare({name, " line length"}, exp_len, len_seen);
    compare({name, " hsync width"}, exp_hsync, hs_seen);
    compare({name, " vsync lines"}, exp_vsync, vs_lines);
    compare({name, " active width"}, exp_active, act_seen);
    compare({name, " draw lines"}, exp_lines, draw_lines);
    compare({name, " colour"}, 32'(exp_color), 32'(color_seen));
    compare({name, " dc balance faults"}, 0, dc_bad);
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles without finishing the patterns", limit_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int fd;
    int n;
    int word;
    int f_tests;
    int errs_before;
    int mode;
    int active;
    int hsw;
    int vsw;
    int len;
    int dlines;
    logic [31:0] data;
    logic [31:0] rd;
    logic        ready;
    string line;
    string name;
    string records[$];
    reset = 1'b1;
    apb = '0;
    f_tests = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    @(negedge clk);
    errs_before = errors;
    compare("reset mode", 32'(video_pkg::mode_off), 32'(video_mode));
    compare("reset red", 32'(code_idle), 32'(tmds_red));
    compare("reset green", 32'(code_idle), 32'(tmds_green));
    compare("reset blue", 32'(code_idle), 32'(tmds_blue));
    report_test("reset state", errs_before);

    fd = $fopen("verif/video_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file verif/video_patterns.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          records.push_back(line);
          if (line.getc(0) == "f") f_tests++;
        end
      end
      $fclose(fd);
      limit_cycles = f_tests * 4 * frame_cycles_max + 20000;

      for (int i = 0; i < records.size(); i++) begin
        line = records[i];
        errs_before = errors;
        if (line.getc(0) == "w" && $sscanf(line, "w %d %h", word, data) == 2) begin
          apb_write(word, data);
        end else if (line.getc(0) == "r" && $sscanf(line, "r %d %h", word, data) == 2) begin
          name = $sformatf("read word %0d", word);
          apb_read(word, rd, ready);
          compare(name, data, rd);
          compare({name, " pready"}, 32'd1, 32'(ready));
          report_test(name, errs_before);
        end else if (line.getc(0) == "f") begin
          n = $sscanf(line, "f %d %d %d %d %d %d %h", mode, active, hsw, vsw, len,
                      dlines, data);
          name = $sformatf("frame mode %0d", mode);
          if (n == 7) begin
            compare({name, " mode"}, mode, 32'(video_mode));
            measure_frame(name, active, hsw, vsw, len, dlines, data[23:0]);
          end else begin
            $display("Pattern line %0d has too few fields for a frame check", i);
            errors++;
          end
          report_test(name, errs_before);
        end else begin
          $display("Pattern line %0d could not be read: %s", i, line);
          errors++;
        end
      end
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== source/video_controller.sv ====
`timescale 1ns/1ns

module video_controller (
  input  logic                   clk,
  input  logic                   reset,
  input  video_pkg::apb_req_t    apb,
  output logic [31:0]            prdata,
  output logic                   pready,
  output video_pkg::video_mode_e video_mode,
  output logic [9:0]             tmds_red,
  output logic [9:0]             tmds_green,
  output logic [9:0]             tmds_blue
);

  video_pkg::video_ctrl_t  ctrl;
  video_pkg::mode_timing_t timing;
  video_pkg::rgb_t         fill_color;
  video_pkg::beam_t        beam;
  video_pkg::beam_t        beam_q;   // Aligned with pixel
  video_pkg::rgb_t         pixel;

  assign pready     = 1'b1;
  assign video_mode = ctrl.mode;

  video_regs u_regs (
    .clk(clk), .reset(reset), .apb(apb), .prdata(prdata),
    .ctrl(ctrl), .timing(timing), .fill_color(fill_color)
  );

  video_timing u_timing (
    .clk(clk), .reset(reset), .ctrl(ctrl), .timing(timing), .beam(beam)
  );

  pixel_color u_pixel (
    .clk(clk), .reset(reset), .beam_in(beam), .fill_color(fill_color),
    .beam_out(beam_q), .pixel(pixel)
  );

  tmds_encoder u_enc_red (
    .clk(clk), .reset(reset), .data(pixel.red), .ctrl(2'b00),
    .enable(beam_q.draw), .symbol(tmds_red)
  );

  tmds_encoder u_enc_green (
    .clk(clk), .reset(reset), .data(pixel.green), .ctrl(2'b00),
    .enable(beam_q.draw), .symbol(tmds_green)
  );

  // Sync travels on blue
  tmds_encoder u_enc_blue (
    .clk(clk), .reset(reset), .data(pixel.blue), .ctrl({beam_q.vsync, beam_q.hsync}),
    .enable(beam_q.draw), .symbol(tmds_blue)
  );

endmodule

// ==== source/tmds_encoder.sv ====
`timescale 1ns/1ns

module tmds_encoder (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] data,
  input  logic [1:0] ctrl,
  input  logic       enable,
  output logic [9:0] symbol
);

  logic [3:0] ones_data;
  logic       use_xnor;
  logic [8:0] q_m;
  logic [3:0] ones_qm;
  logic [3:0] balance;      // Ones minus four, two's complement
  logic [3:0] disparity;
  logic       sign_eq;
  logic       neutral;
  logic       invert;
  logic [3:0] disp_step;
  logic [3:0] disp_next;
  logic [9:0] data_word;
  logic [9:0] symbol_buf;

  always_comb begin
    ones_data = '0;
    for (int i = 0; i < 8; i++) ones_data = ones_data + {3'd0, data[i]};
    use_xnor = (ones_data > 4'd4) || (ones_data == 4'd4 && !data[0]);

    // Transition minimising chain
    q_m[0] = data[0];
    for (int i = 1; i < 8; i++) q_m[i] = q_m[i-1] ^ data[i] ^ use_xnor;
    q_m[8] = ~use_xnor;

    ones_qm = '0;
    for (int i = 0; i < 8; i++) ones_qm = ones_qm + {3'd0, q_m[i]};
    balance = ones_qm - 4'd4;

    sign_eq   = balance[3] == disparity[3];
    neutral   = (balance == 4'd0) || (disparity == 4'd0);
    invert    = neutral ? ~q_m[8] : sign_eq;
    disp_step = balance - {3'd0, (q_m[8] ^ ~sign_eq) & ~neutral};
    disp_next = invert ? disparity - disp_step : disparity + disp_step;
    data_word = {invert, q_m[8], q_m[7:0] ^ {8{invert}}};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      symbol_buf <= video_pkg::ctrl_codes[0];
      symbol     <= video_pkg::ctrl_codes[0];
      disparity  <= '0;
    end else begin
      symbol_buf <= enable ? data_word : video_pkg::ctrl_codes[ctrl];
      symbol     <= symbol_buf;
      disparity  <= enable ? disp_next : 4'd0;  // Cleared in blanking
    end
  end

endmodule

// ==== source/pixel_color.sv ====
`timescale 1ns/1ns

module pixel_color (
  input  logic             clk,
  input  logic             reset,
  input  video_pkg::beam_t beam_in,
  input  video_pkg::rgb_t  fill_color,
  output video_pkg::beam_t beam_out,
  output video_pkg::rgb_t  pixel
);

  // Beam delayed to line up with the colour register
  always_ff @(posedge clk) begin
    if (reset) begin
      beam_out <= '0;
    end else begin
      beam_out <= beam_in;
    end
  end

  // Text or graphic sources would be mixed in here
  always_ff @(posedge clk) begin
    if (beam_in.draw) begin
      pixel <= fill_color;
    end else begin
      pixel <= '0;  // Black outside the draw area
    end
  end

endmodule

// ==== source/video_timing.sv ====
`timescale 1ns/1ns

module video_timing (
  input  logic                    clk,
  input  logic                    reset,
  input  video_pkg::video_ctrl_t  ctrl,
  input  video_pkg::mode_timing_t timing,
  output video_pkg::beam_t        beam
);

  video_pkg::video_mode_e  mode_q;
  video_pkg::mode_timing_t t_q;   // Figures of the running frame

  logic [10:0] h_cnt;
  logic [9:0]  v_cnt;
  logic        line_end;
  logic        frame_end;

  assign line_end  = h_cnt == t_q.h_last;
  assign frame_end = line_end && (v_cnt == t_q.v_last);

  // New mode is taken only between frames
  always_ff @(posedge clk) begin
    if (reset) begin
      mode_q <= video_pkg::mode_off;
      t_q    <= '0;
      h_cnt  <= '0;
      v_cnt  <= '0;
    end else if (mode_q == video_pkg::mode_off || frame_end) begin
      mode_q <= ctrl.mode;
      t_q    <= timing;
      h_cnt  <= '0;
      v_cnt  <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      v_cnt <= v_cnt + 10'd1;
    end else begin
      h_cnt <= h_cnt + 11'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      beam <= '0;
    end else if (mode_q == video_pkg::mode_off) begin
      beam <= '0;  // Idle display
    end else begin
      beam.draw        <= (h_cnt < t_q.h_draw_end) && (v_cnt < t_q.v_draw_end);
      beam.hsync       <= (h_cnt >= t_q.h_sync_start) && (h_cnt < t_q.h_sync_end);
      beam.vsync       <= (v_cnt >= t_q.v_sync_start) && (v_cnt < t_q.v_sync_end);
      beam.line_start  <= h_cnt == 11'd0;
      beam.frame_start <= (h_cnt == 11'd0) && (v_cnt == 10'd0);
    end
  end

endmodule

// ==== source/video_regs.sv ====
`timescale 1ns/1ns

module video_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  video_pkg::apb_req_t     apb,
  output logic [31:0]             prdata,
  output video_pkg::video_ctrl_t  ctrl,
  output video_pkg::mode_timing_t timing,
  output video_pkg::rgb_t         fill_color
);

  video_pkg::reg_sel_e apb_reg;  // Word address of the previous cycle
  logic                write_en;

  logic [31:6] text_addr;
  logic [31:6] graphic_addr;
  logic [video_pkg::palette_index_w-1:0] color_index;
  logic [video_pkg::palette_index_w-1:0] fill_index;

  video_pkg::rgb_t palette [video_pkg::palette_size];

  assign write_en = apb.psel & apb.penable & apb.pwrite;

  always_ff @(posedge clk) begin
    apb_reg <= video_pkg::reg_sel_e'(apb.paddr[4:2]);
    if (reset) begin
      ctrl        <= '0;
      timing      <= '0;
      color_index <= '0;
      fill_index  <= '0;
    end else if (write_en) begin
      case (apb_reg)
        video_pkg::reg_control: begin
          ctrl <= video_pkg::video_ctrl_t'(apb.pwdata[11:0]);
          case (video_pkg::video_mode_e'(apb.pwdata[1:0]))
            video_pkg::mode_640:  timing <= video_pkg::timing_640;
            video_pkg::mode_1024: timing <= video_pkg::timing_1024;
            video_pkg::mode_1280: timing <= video_pkg::timing_1280;
            default: ;  // Off leaves the old figures in place
          endcase
        end
        video_pkg::reg_color_index:
          color_index <= apb.pwdata[video_pkg::palette_index_w-1:0];
        video_pkg::reg_fill_index:
          fill_index <= apb.pwdata[video_pkg::palette_index_w-1:0];
        default: ;
      endcase
    end
  end

  // Base addresses and colour table
  always_ff @(posedge clk) begin
    if (write_en) begin
      case (apb_reg)
        video_pkg::reg_text_addr:    text_addr <= apb.pwdata[31:6];
        video_pkg::reg_graphic_addr: graphic_addr <= apb.pwdata[31:6];
        video_pkg::reg_color_data:   palette[color_index] <= apb.pwdata[23:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (apb_reg)
      video_pkg::reg_control:      prdata = {20'd0, ctrl};
      video_pkg::reg_text_addr:    prdata = {text_addr, 6'd0};
      video_pkg::reg_graphic_addr: prdata = {graphic_addr, 6'd0};
      video_pkg::reg_color_index:  prdata = {28'd0, color_index};
      video_pkg::reg_fill_index:   prdata = {28'd0, fill_index};
      default:                     prdata = 32'd0;  // Colour data is write only
    endcase
  end

  assign fill_color = palette[fill_index];

endmodule

// ==== source/video_pkg.sv ====
package video_pkg;

  typedef enum logic [1:0] {
    mode_off  = 2'd0,
    mode_640  = 2'd1,
    mode_1024 = 2'd2,
    mode_1280 = 2'd3
  } video_mode_e;

  // APB word index, paddr[4:2]
  typedef enum logic [2:0] {
    reg_control      = 3'd0,
    reg_text_addr    = 3'd1,
    reg_graphic_addr = 3'd2,
    reg_color_index  = 3'd3,
    reg_color_data   = 3'd4,
    reg_fill_index   = 3'd5
  } reg_sel_e;

  typedef struct packed {
    logic [10:0] h_draw_end;
    logic [10:0] h_sync_start;
    logic [10:0] h_sync_end;
    logic [10:0] h_last;
    logic [9:0]  v_draw_end;
    logic [9:0]  v_sync_start;
    logic [9:0]  v_sync_end;
    logic [9:0]  v_last;
  } mode_timing_t;

  localparam mode_timing_t timing_640 = '{
    h_draw_end: 11'd640, h_sync_start: 11'd656, h_sync_end: 11'd752, h_last: 11'd799,
    v_draw_end: 10'd480, v_sync_start: 10'd490, v_sync_end: 10'd492, v_last: 10'd524
  };
  localparam mode_timing_t timing_1024 = '{
    h_draw_end: 11'd1024, h_sync_start: 11'd1048, h_sync_end: 11'd1184, h_last: 11'd1343,
    v_draw_end: 10'd768, v_sync_start: 10'd771, v_sync_end: 10'd777, v_last: 10'd805
  };
  localparam mode_timing_t timing_1280 = '{
    h_draw_end: 11'd1280, h_sync_start: 11'd1390, h_sync_end: 11'd1430, h_last: 11'd1649,
    v_draw_end: 10'd720, v_sync_start: 10'd725, v_sync_end: 10'd730, v_last: 10'd749
  };

  typedef struct packed {
    logic [4:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // Control word bits 11..0
  typedef struct packed {
    logic [7:0]  retained;      // Alpha and font bits, readback only
    logic        show_graphic;
    logic        show_text;
    video_mode_e mode;
  } video_ctrl_t;

  typedef struct packed {
    logic draw;
    logic hsync;
    logic vsync;
    logic line_start;
    logic frame_start;
  } beam_t;

  localparam int palette_size    = 16;
  localparam int palette_index_w = $clog2(palette_size);

  // Control symbols, index is {vsync, hsync}
  localparam logic [3:0][9:0] ctrl_codes = {
    10'b1010101011,
    10'b0101010100,
    10'b0010101011,
    10'b1101010100
  };

endpackage
